//--- src.f
src/mem_geometry_pkg.sv
src/mem_port_pkg.sv
src/bank_port_if.sv
src/dp_ram_bank.sv
src/bank_array.sv
src/port_decoder.sv
src/banked_dp_mem.sv
test/tb_banked_dp_mem.sv

//--- Makefile
# Verilator build for the banked dual-port memory

TOP = tb_banked_dp_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module banked_dp_mem
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f $(shell cat src.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_banked_dp_mem.sv
`timescale 1ns/1ps

module tb_banked_dp_mem;
	import mem_geometry_pkg::*;

	localparam int RESET_CYCLES  = 4;
	localparam int POOL_SIZE     = 16; // power of two, used as a mask
	localparam int RANDOM_CYCLES = 200;
	localparam int DIRECTED_MAX  = 40; // upper bound on any directed test
	localparam int TEST_CYCLES   = RESET_CYCLES + 5 * DIRECTED_MAX + RANDOM_CYCLES + 8;
	localparam int MAX_CYCLES    = 2 * TEST_CYCLES;

	logic      CLK;
	logic      rst_n;
	logic      a_req;
	logic      a_we;
	mem_addr_t a_addr;
	mem_data_t a_wdata;
	mem_data_t a_rdata;
	logic      a_rvalid;
	logic      b_req;
	logic      b_we;
	mem_addr_t b_addr;
	mem_data_t b_wdata;
	mem_data_t b_rdata;
	logic      b_rvalid;

	integer      seed = 72;
	int          errors = 0;
	int          errors_at_start = 0;
	int          checks = 0;
	int          tests_run = 0;
	int unsigned cycle_count = 0;

	mem_data_t model [mem_addr_t];  // every in-range word written so far
	bit        issued [mem_addr_t]; // words the random test has written
	bit        pend_a;              // a read was sampled on the last edge
	bit        pend_b;
	mem_data_t want_a;
	mem_data_t want_b;

	banked_dp_mem #(
		.NUM_BANKS       (NUM_BANKS),
		.BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
		.DATA_WIDTH      (DATA_WIDTH)
	) u_banked_dp_mem (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.a_req    (a_req),
		.a_we     (a_we),
		.a_addr   (a_addr),
		.a_wdata  (a_wdata),
		.a_rdata  (a_rdata),
		.a_rvalid (a_rvalid),
		.b_req    (b_req),
		.b_we     (b_we),
		.b_addr   (b_addr),
		.b_wdata  (b_wdata),
		.b_rdata  (b_rdata),
		.b_rvalid (b_rvalid)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// the upper five address bits name the bank, only 0 to 29 exist
	function automatic bit unmapped(input mem_addr_t addr);
		return int'(addr[ADDR_WIDTH-1 -: BANK_SEL_WIDTH]) >= NUM_BANKS;
	endfunction

	function automatic mem_addr_t make_addr(input int bank, input int word);
		return {bank[BANK_SEL_WIDTH-1:0], word[BANK_ADDR_WIDTH-1:0]};
	endfunction

	function automatic mem_data_t expected_word(input mem_addr_t addr);
		if (unmapped(addr) || !model.exists(addr)) begin
			return '0;
		end
		return model[addr];
	endfunction

	function automatic bit known(input mem_addr_t addr);
		return unmapped(addr) || issued.exists(addr);
	endfunction

	task automatic check_flag(input string name, input logic want, input logic got);
		assert (got === want) checks = checks + 1;
		else begin
			errors = errors + 1;
			$display("FAILED %s expected 0x%h got 0x%h at %0t", name, want, got, $time);
		end
	endtask

	task automatic check_word(input string name, input mem_data_t want, input mem_data_t got);
		assert (got === want) checks = checks + 1;
		else begin
			errors = errors + 1;
			$display("FAILED %s expected 0x%h got 0x%h at %0t", name, want, got, $time);
		end
	endtask

	// Reads the requests that the DUT samples on this edge, so the
	// expected words come from the model before this edge's writes.
	always @(posedge CLK) begin
		if (!rst_n) begin
			pend_a = 1'b0;
			pend_b = 1'b0;
		end else begin
			check_flag("a_rvalid", pend_a, a_rvalid);
			check_flag("b_rvalid", pend_b, b_rvalid);
			if (pend_a) begin
				check_word("a_rdata", want_a, a_rdata);
			end
			if (pend_b) begin
				check_word("b_rdata", want_b, b_rdata);
			end
			pend_a = a_req && !a_we;
			pend_b = b_req && !b_we;
			want_a = expected_word(a_addr);
			want_b = expected_word(b_addr);
			if (a_req && a_we && !unmapped(a_addr)) begin
				model[a_addr] = a_wdata;
			end
			if (b_req && b_we && !unmapped(b_addr)) begin
				model[b_addr] = b_wdata;
			end
		end
	end

	task automatic drive_a(input logic req, input logic we, input mem_addr_t addr,
			input mem_data_t data);
		a_req   <= req;
		a_we    <= we;
		a_addr  <= addr;
		a_wdata <= data;
	endtask

	task automatic drive_b(input logic req, input logic we, input mem_addr_t addr,
			input mem_data_t data);
		b_req   <= req;
		b_we    <= we;
		b_addr  <= addr;
		b_wdata <= data;
	endtask

	// the request driven before this call is sampled on this edge
	task automatic clock_in();
		@(posedge CLK);
		a_req <= 1'b0;
		b_req <= 1'b0;
	endtask

	// the last read comes back one edge later, so two edges drain it
	task automatic finish_test(input string name);
		repeat (2) @(posedge CLK);
		@(negedge CLK); // the checks of the last edge are counted by now
		tests_run = tests_run + 1;
		$display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
		errors_at_start = errors;
		@(posedge CLK);
	endtask

	task automatic idle_after_reset();
		repeat (8) clock_in(); // both rvalid outputs are checked low on every edge
		finish_test("idle after reset");
	endtask

	task automatic write_then_read_back();
		mem_addr_t addr;
		addr = make_addr(3, 77);
		drive_a(1'b1, 1'b1, addr, mem_data_t'($random(seed)));
		clock_in();
		drive_a(1'b1, 1'b0, addr, '0);
		clock_in();
		clock_in(); // gap shows rvalid drops after one cycle
		drive_b(1'b1, 1'b0, addr, '0);
		clock_in();
		drive_a(1'b1, 1'b0, addr, '0);
		drive_b(1'b1, 1'b0, addr, '0);
		clock_in();
		finish_test("write and read back");
	endtask

	task automatic bank_isolation();
		int banks [3] = '{0, 15, 29};
		for (int i = 0; i < 3; i++) begin
			if (i % 2 == 0) begin
				drive_a(1'b1, 1'b1, make_addr(banks[i], 341), mem_data_t'($random(seed)));
			end else begin
				drive_b(1'b1, 1'b1, make_addr(banks[i], 341), mem_data_t'($random(seed)));
			end
			clock_in();
		end
		for (int i = 0; i < 3; i++) begin
			drive_a(1'b1, 1'b0, make_addr(banks[i], 341), '0);
			drive_b(1'b1, 1'b0, make_addr(banks[2 - i], 341), '0);
			clock_in();
		end
		finish_test("bank isolation");
	endtask

	task automatic unmapped_banks();
		mem_addr_t base;
		base = make_addr(0, 5);
		drive_a(1'b1, 1'b1, base, 18'h2a5a5);
		clock_in();
		// bank 0 word 5 must survive writes aimed at banks 30 and 31
		drive_a(1'b1, 1'b1, make_addr(30, 5), 18'h11111);
		drive_b(1'b1, 1'b1, make_addr(31, 5), 18'h22222);
		clock_in();
		drive_a(1'b1, 1'b0, base, '0);
		drive_b(1'b1, 1'b0, make_addr(30, 5), '0);
		clock_in();
		drive_a(1'b1, 1'b0, make_addr(31, 5), '0);
		drive_b(1'b1, 1'b0, make_addr(31, 900), '0);
		clock_in();
		finish_test("unmapped banks");
	endtask

	task automatic random_traffic();
		mem_addr_t pool [POOL_SIZE];
		mem_addr_t aa;
		mem_addr_t bb;
		int        r;
		logic      wa;
		logic      wb;
		logic      b_on;
		for (int i = 0; i < POOL_SIZE; i++) begin
			pool[i] = mem_addr_t'($random(seed));
		end
		pool[0] = make_addr(30, 12);
		pool[1] = make_addr(31, 13);
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			r  = $random(seed);
			aa = pool[(r >> 4) & (POOL_SIZE - 1)];
			bb = pool[(r >> 8) & (POOL_SIZE - 1)];
			wa = r[0] || !known(aa); // a word is written before it is read
			wb = r[1] || !known(bb);
			b_on = !(wa && wb && aa == bb); // two writes never hit one word
			drive_a(1'b1, wa, aa, mem_data_t'($random(seed)));
			drive_b(b_on, wb, bb, mem_data_t'($random(seed)));
			if (wa && !unmapped(aa)) begin
				issued[aa] = 1'b1;
			end
			if (b_on && wb && !unmapped(bb)) begin
				issued[bb] = 1'b1;
			end
			clock_in();
		end
		finish_test("random traffic");
	endtask

	task automatic read_during_write();
		mem_addr_t addr;
		addr = make_addr(12, 500);
		drive_a(1'b1, 1'b1, addr, 18'h0f0f0);
		clock_in();
		drive_a(1'b1, 1'b0, addr, '0);
		drive_b(1'b1, 1'b1, addr, 18'h3c3c3);
		clock_in();
		drive_a(1'b1, 1'b0, addr, '0);
		drive_b(1'b1, 1'b0, addr, '0);
		clock_in();
		drive_a(1'b1, 1'b1, addr, 18'h12345);
		drive_b(1'b1, 1'b0, addr, '0);
		clock_in();
		drive_a(1'b1, 1'b0, addr, '0);
		drive_b(1'b1, 1'b0, addr, '0);
		clock_in();
		finish_test("read during write");
	endtask

	initial begin
		rst_n   = 1'b0;
		a_req   = 1'b0;
		a_we    = 1'b0;
		a_addr  = '0;
		a_wdata = '0;
		b_req   = 1'b0;
		b_we    = 1'b0;
		b_addr  = '0;
		b_wdata = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rst_n <= 1'b1;
		idle_after_reset();
		write_then_read_back();
		bank_isolation();
		unmapped_banks();
		random_traffic();
		read_during_write();
		@(negedge CLK);
		$display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("Test passed");
		end else begin
			if (checks == 0) begin
				$display("no check was carried out, so nothing was verified");
			end
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- src/banked_dp_mem.sv
`timescale 1ns/1ps

module banked_dp_mem #(
	parameter int NUM_BANKS       = mem_geometry_pkg::NUM_BANKS,
	parameter int BANK_ADDR_WIDTH = mem_geometry_pkg::BANK_ADDR_WIDTH,
	parameter int DATA_WIDTH      = mem_geometry_pkg::DATA_WIDTH
) (
	input  logic                        CLK,
	input  logic                        rst_n,

	input  logic                        a_req,
	input  logic                        a_we,
	input  mem_geometry_pkg::mem_addr_t a_addr,
	input  mem_geometry_pkg::mem_data_t a_wdata,
	output mem_geometry_pkg::mem_data_t a_rdata,
	output logic                        a_rvalid,

	input  logic                        b_req,
	input  logic                        b_we,
	input  mem_geometry_pkg::mem_addr_t b_addr,
	input  mem_geometry_pkg::mem_data_t b_wdata,
	output mem_geometry_pkg::mem_data_t b_rdata,
	output logic                        b_rvalid
);
	import mem_port_pkg::*;

	port_req_t req_a;
	port_req_t req_b;

	bank_port_if #(.NUM_BANKS(NUM_BANKS)) bus_a ();
	bank_port_if #(.NUM_BANKS(NUM_BANKS)) bus_b ();

	assign req_a = '{req: a_req, we: a_we, addr: a_addr, wdata: a_wdata};
	assign req_b = '{req: b_req, we: b_we, addr: b_addr, wdata: b_wdata};

	port_decoder #(
		.NUM_BANKS       (NUM_BANKS),
		.BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
	) u_port_decoder (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.req_a    (req_a),
		.req_b    (req_b),
		.bus_a    (bus_a),
		.bus_b    (bus_b),
		.rvalid_a (a_rvalid),
		.rvalid_b (b_rvalid)
	);

	bank_array #(
		.NUM_BANKS       (NUM_BANKS),
		.BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
		.DATA_WIDTH      (DATA_WIDTH)
	) u_bank_array (
		.CLK   (CLK),
		.bus_a (bus_a),
		.bus_b (bus_b)
	);

	assign a_rdata = bus_a.rdata; // zero whenever no read is returning
	assign b_rdata = bus_b.rdata;

endmodule

//--- src/port_decoder.sv
`timescale 1ns/1ps

module port_decoder #(
	parameter int NUM_BANKS       = mem_geometry_pkg::NUM_BANKS,
	parameter int BANK_ADDR_WIDTH = mem_geometry_pkg::BANK_ADDR_WIDTH
) (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  mem_port_pkg::port_req_t req_a,
	input  mem_port_pkg::port_req_t req_b,
	bank_port_if.ctrl               bus_a,
	bank_port_if.ctrl               bus_b,
	output logic                    rvalid_a,
	output logic                    rvalid_b
);
	import mem_geometry_pkg::*;
	import mem_port_pkg::*;

	logic       rd_a;
	logic       rd_b;
	rd_return_t ret_a;
	rd_return_t ret_b;

	function automatic bank_sel_t bank_of(input mem_addr_t addr);
		return bank_sel_t'(addr >> BANK_ADDR_WIDTH);
	endfunction

	function automatic logic in_range(input mem_addr_t addr);
		return int'(bank_of(addr)) < NUM_BANKS;
	endfunction

	// One comparator per existing bank. A bank number past the last bank
	// matches none of them, so such a write is dropped here.
	function automatic logic [NUM_BANKS-1:0] write_enables(input port_req_t r);
		logic [NUM_BANKS-1:0] we;
		for (int i = 0; i < NUM_BANKS; i++) begin
			we[i] = r.req && r.we && (bank_of(r.addr) == bank_sel_t'(i));
		end
		return we;
	endfunction

	assign rd_a = req_a.req && !req_a.we;
	assign rd_b = req_b.req && !req_b.we;

	assign bus_a.we     = write_enables(req_a);
	assign bus_a.addr   = bank_addr_t'(req_a.addr); // word bits only
	assign bus_a.wdata  = req_a.wdata;
	assign bus_a.rd_ret = ret_a;

	assign bus_b.we     = write_enables(req_b);
	assign bus_b.addr   = bank_addr_t'(req_b.addr);
	assign bus_b.wdata  = req_b.wdata;
	assign bus_b.rd_ret = ret_b;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			rvalid_a  <= 1'b0;
			rvalid_b  <= 1'b0;
			ret_a.hit <= 1'b0;
			ret_b.hit <= 1'b0;
		end else begin
			rvalid_a  <= rd_a; // same edge as the bank output register
			rvalid_b  <= rd_b;
			ret_a.hit <= rd_a && in_range(req_a.addr); // a miss reads back zero
			ret_b.hit <= rd_b && in_range(req_b.addr);
		end
		if (rd_a) begin
			ret_a.bank <= bank_of(req_a.addr);
		end
		if (rd_b) begin
			ret_b.bank <= bank_of(req_b.addr);
		end
	end

endmodule

//--- src/bank_array.sv
`timescale 1ns/1ps

module bank_array #(
	parameter int NUM_BANKS       = mem_geometry_pkg::NUM_BANKS,
	parameter int BANK_ADDR_WIDTH = mem_geometry_pkg::BANK_ADDR_WIDTH,
	parameter int DATA_WIDTH      = mem_geometry_pkg::DATA_WIDTH
) (
	input logic        CLK,
	bank_port_if.array bus_a,
	bank_port_if.array bus_b
);
	import mem_geometry_pkg::*;

	mem_data_t rdata_a [NUM_BANKS]; // registered outputs of every bank, port a
	mem_data_t rdata_b [NUM_BANKS];

	// every bank sees both addresses and write words, only its own enable
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		dp_ram_bank #(
			.BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
			.DATA_WIDTH      (DATA_WIDTH)
		) u_dp_ram_bank (
			.CLK     (CLK),
			.we_a    (bus_a.we[i]),
			.we_b    (bus_b.we[i]),
			.addr_a  (bus_a.addr),
			.addr_b  (bus_b.addr),
			.wdata_a (bus_a.wdata),
			.wdata_b (bus_b.wdata),
			.rdata_a (rdata_a[i]),
			.rdata_b (rdata_b[i])
		);
	end

	// the select is the bank number from the request cycle, not the current one
	assign bus_a.rdata = bus_a.rd_ret.hit ? rdata_a[bus_a.rd_ret.bank] : '0;
	assign bus_b.rdata = bus_b.rd_ret.hit ? rdata_b[bus_b.rd_ret.bank] : '0;

endmodule

//--- src/dp_ram_bank.sv
`timescale 1ns/1ps

module dp_ram_bank #(
	parameter int BANK_ADDR_WIDTH = mem_geometry_pkg::BANK_ADDR_WIDTH,
	parameter int DATA_WIDTH      = mem_geometry_pkg::DATA_WIDTH
) (
	input  logic                         CLK,
	input  logic                         we_a,
	input  logic                         we_b,
	input  mem_geometry_pkg::bank_addr_t addr_a,
	input  mem_geometry_pkg::bank_addr_t addr_b,
	input  mem_geometry_pkg::mem_data_t  wdata_a,
	input  mem_geometry_pkg::mem_data_t  wdata_b,
	output mem_geometry_pkg::mem_data_t  rdata_a,
	output mem_geometry_pkg::mem_data_t  rdata_b
);

	logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

	// Both ports sit in one process so the array has a single writer.
	// The reads sample the array before this edge's writes land, which
	// gives read-first behaviour on either port.
	always_ff @(posedge CLK) begin
		rdata_a <= mem[addr_a];
		rdata_b <= mem[addr_b];
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end
		if (we_b) begin
			mem[addr_b] <= wdata_b; // port b wins a same-word collision
		end
	end

endmodule

//--- src/bank_port_if.sv
`timescale 1ns/1ps

interface bank_port_if #(
	parameter int NUM_BANKS = mem_geometry_pkg::NUM_BANKS
);
	import mem_geometry_pkg::*;
	import mem_port_pkg::*;

	logic [NUM_BANKS-1:0] we; // at most one bit high
	bank_addr_t           addr;
	mem_data_t            wdata;
	rd_return_t           rd_ret;
	mem_data_t            rdata;

	modport ctrl (
		output we,
		output addr,
		output wdata,
		output rd_ret,
		input  rdata
	);

	modport array (
		input  we,
		input  addr,
		input  wdata,
		input  rd_ret,
		output rdata
	);

endinterface

//--- src/mem_port_pkg.sv
package mem_port_pkg;

	// one request per cycle per port, no back-pressure
	typedef struct packed {
		logic                        req;
		logic                        we;    // low for a read
		mem_geometry_pkg::mem_addr_t addr;
		mem_geometry_pkg::mem_data_t wdata;
	} port_req_t;

	// travels one cycle behind the request, next to the bank output register
	typedef struct packed {
		logic                        hit;   // read went to an existing bank
		mem_geometry_pkg::bank_sel_t bank;
	} rd_return_t;

endpackage

//--- src/mem_geometry_pkg.sv
package mem_geometry_pkg;

	parameter int DATA_WIDTH      = 18;
	parameter int BANK_ADDR_WIDTH = 10; // 1024 words per bank
	parameter int BANK_SEL_WIDTH  = 5;
	parameter int NUM_BANKS       = 30; // numbers 30 and 31 are unmapped
	parameter int ADDR_WIDTH      = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;

	typedef logic [DATA_WIDTH-1:0]      mem_data_t;
	typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
	typedef logic [BANK_SEL_WIDTH-1:0]  bank_sel_t;

	// bank number in the upper bits, word in the lower bits
	typedef logic [ADDR_WIDTH-1:0]      mem_addr_t;

endpackage
